// File: design/via_pkg.sv
package via_pkg;

	// ==============================
	// bus types
	// ==============================
	typedef logic [31:0] word_t;

	// register map, 10 and 15 unused
	typedef enum logic [3:0] {
		PB   = 4'd0,
		PA   = 4'd1,
		DDRB = 4'd2,
		DDRA = 4'd3,
		T1CL = 4'd4,
		T1CH = 4'd5,
		T1LL = 4'd6,
		T1LH = 4'd7,
		T2CL = 4'd8,
		T2CH = 4'd9,
		ACR  = 4'd11,
		PCR  = 4'd12,
		IFR  = 4'd13,
		IER  = 4'd14
	} reg_addr_e;

	typedef enum logic [1:0] {
		ONESHOT,
		FREERUN,
		PULSE_COUNT // counts pb6 falling edges
	} timer_mode_e;

	// ==============================
	// interrupt sources
	// ==============================
	typedef enum logic [1:0] {
		IRQ_CA1 = 2'd0,
		IRQ_CB1 = 2'd1,
		IRQ_T1  = 2'd2,
		IRQ_T2  = 2'd3
	} irq_src_e;

	localparam int NUM_IRQ = 4;

	// register field positions
	localparam int ACR_PA_LE    = 0;
	localparam int ACR_PB_LE    = 1;
	localparam int ACR_T2_PULSE = 5;
	localparam int ACR_T1_FREE  = 6;
	localparam int PCR_CA1_POS  = 0;
	localparam int PCR_CB1_POS  = 4;
	localparam int IER_SET      = 7; // 1 sets, 0 clears
	localparam int IFR_ANY      = 7;

endpackage

// File: design/via_port.sv
`timescale 1ns/10ps

module via_port import via_pkg::*; #(
	parameter int PORT_W = 32
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              out_wr_i,
	input  logic              ddr_wr_i,
	input  logic [3:0]        sel_i,
	input  word_t             wdata_i,
	input  logic              latch_en_i,
	input  logic              edge_pos_i,
	input  logic              strobe_pin_i,
	input  logic [PORT_W-1:0] pins_i,
	output logic [PORT_W-1:0] out_o,
	output logic [PORT_W-1:0] oe_o,
	output logic [PORT_W-1:0] rd_o,
	output logic              strobe_evt_o
);

	logic [PORT_W-1:0] out_q;
	logic [PORT_W-1:0] ddr_q;
	logic [PORT_W-1:0] live;
	logic              strb_sync_q;
	logic              strb_prev_q;
	logic              strb_edge;

	// output bits read back the latch
	assign live = (ddr_q & out_q) | (~ddr_q & pins_i);

	assign strb_edge = edge_pos_i ? (strb_sync_q & ~strb_prev_q)
	                              : (~strb_sync_q & strb_prev_q);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			out_q        <= '0;
			ddr_q        <= '0; // all inputs
			strb_sync_q  <= 1'b0;
			strb_prev_q  <= 1'b0;
			strobe_evt_o <= 1'b0;
		end else begin
			for (int i = 0; i < PORT_W; i++) begin
				if (out_wr_i && sel_i[i/8])
					out_q[i] <= wdata_i[i];
				if (ddr_wr_i && sel_i[i/8])
					ddr_q[i] <= wdata_i[i];
			end
			strb_sync_q  <= strobe_pin_i;
			strb_prev_q  <= strb_sync_q;
			strobe_evt_o <= strb_edge; // second edge after the pin
		end
	end

	// input latch, transparent unless latching is on
	always_ff @(posedge clk_i) begin
		if (!latch_en_i || strobe_evt_o)
			rd_o <= live;
	end

	assign out_o = out_q;
	assign oe_o  = ddr_q;

endmodule

// File: design/via_timer.sv
`timescale 1ns/10ps

module via_timer import via_pkg::*; #(
	parameter int TIMER_W = 32
) (
	input  logic               clk_i,
	input  logic               rst_i,
	input  timer_mode_e        mode_i,
	input  logic               latch_wr_i,
	input  logic               load_i,
	input  word_t              wdata_i,
	input  logic               pulse_pin_i,
	output logic [TIMER_W-1:0] count_o,
	output logic [TIMER_W-1:0] latch_o,
	output logic               zero_evt_o
);

	logic [TIMER_W-1:0] count_q;
	logic [TIMER_W-1:0] latch_q;
	logic               pin_sync_q;
	logic               pin_prev_q;
	logic               pin_fall;
	logic               dec;

	assign pin_fall = pin_prev_q & ~pin_sync_q;

	always_comb begin
		case (mode_i)
			ONESHOT, FREERUN: dec = 1'b1;
			PULSE_COUNT:      dec = pin_fall;
			default:          dec = 1'b0;
		endcase
	end

	// decrement out of zero
	assign zero_evt_o = dec & ~load_i & (count_q == '0);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			count_q    <= '1;
			latch_q    <= '0;
			pin_sync_q <= 1'b0;
			pin_prev_q <= 1'b0;
		end else begin
			pin_sync_q <= pulse_pin_i;
			pin_prev_q <= pin_sync_q;
			if (load_i) begin
				count_q <= wdata_i[TIMER_W-1:0];
				latch_q <= wdata_i[TIMER_W-1:0];
			end else begin
				if (latch_wr_i)
					latch_q <= wdata_i[TIMER_W-1:0];
				if (zero_evt_o && mode_i == FREERUN)
					count_q <= latch_q; // period is latch+1
				else if (dec)
					count_q <= count_q - 1'b1; // wraps to all ones
			end
		end
	end

	assign count_o = count_q;
	assign latch_o = latch_q;

	a_wr_excl: assert property (@(posedge clk_i) disable iff (rst_i)
		!(latch_wr_i && load_i));

endmodule

// File: design/via_irq.sv
`timescale 1ns/10ps

module via_irq import via_pkg::*; (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic [NUM_IRQ-1:0] evt_i,
	input  logic [NUM_IRQ-1:0] clr_i,
	input  logic               ier_wr_i,
	input  word_t              wdata_i,
	output logic [NUM_IRQ-1:0] ifr_o,
	output logic [NUM_IRQ-1:0] ier_o,
	output logic               irq_o
);

	logic [NUM_IRQ-1:0] flag_q;
	logic [NUM_IRQ-1:0] en_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			flag_q <= '0;
			en_q   <= '0;
			irq_o  <= 1'b0;
		end else begin
			flag_q <= (flag_q & ~clr_i) | evt_i; // event beats clear
			if (ier_wr_i) begin
				if (wdata_i[IER_SET])
					en_q <= en_q | wdata_i[NUM_IRQ-1:0];
				else
					en_q <= en_q & ~wdata_i[NUM_IRQ-1:0];
			end
			irq_o <= |(flag_q & en_q);
		end
	end

	assign ifr_o = flag_q;
	assign ier_o = en_q;

	a_irq_cause: assert property (@(posedge clk_i) disable iff (rst_i)
		irq_o |-> $past(|(flag_q & en_q)));

endmodule

// File: design/via_regctl.sv
`timescale 1ns/10ps

module via_regctl import via_pkg::*; #(
	parameter int PORT_W  = 32,
	parameter int TIMER_W = 32
) (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               cs_i,
	input  logic               we_i,
	input  reg_addr_e          adr_i,
	input  logic [3:0]         sel_i,
	input  word_t              dat_i,
	input  logic [PORT_W-1:0]  pa_rd_i,
	input  logic [PORT_W-1:0]  pb_rd_i,
	input  logic [TIMER_W-1:0] t1_count_i,
	input  logic [TIMER_W-1:0] t1_latch_i,
	input  logic [TIMER_W-1:0] t2_count_i,
	input  logic [TIMER_W-1:0] t2_latch_i,
	input  logic [NUM_IRQ-1:0] ifr_i,
	input  logic [NUM_IRQ-1:0] ier_i,
	input  logic               irq_i,
	output logic               ack_o,
	output word_t              dat_o,
	output logic               pa_out_wr_o,
	output logic               pa_ddr_wr_o,
	output logic               pb_out_wr_o,
	output logic               pb_ddr_wr_o,
	output logic               pa_le_o,
	output logic               pb_le_o,
	output logic               ca1_pos_o,
	output logic               cb1_pos_o,
	output logic               t1_latch_wr_o,
	output logic               t1_load_o,
	output timer_mode_e        t1_mode_o,
	output logic               t2_latch_wr_o,
	output logic               t2_load_o,
	output timer_mode_e        t2_mode_o,
	output logic [NUM_IRQ-1:0] irq_clr_o,
	output logic               ier_wr_o
);

	logic       acc_wr;
	logic       acc_rd;
	logic [7:0] acr_q;
	logic [7:0] pcr_q;
	word_t      rdata;

	assign acc_wr = cs_i & we_i;
	assign acc_rd = cs_i & ~we_i;

	// ==============================
	// write strobes
	// ==============================
	assign pa_out_wr_o   = acc_wr && adr_i == PA && |sel_i; // no lane, no write
	assign pa_ddr_wr_o   = acc_wr && adr_i == DDRA && |sel_i;
	assign pb_out_wr_o   = acc_wr && adr_i == PB && |sel_i;
	assign pb_ddr_wr_o   = acc_wr && adr_i == DDRB && |sel_i;
	assign t1_latch_wr_o = acc_wr && adr_i == T1LL;
	assign t1_load_o     = acc_wr && adr_i == T1CH; // counter and latch
	assign t2_latch_wr_o = acc_wr && adr_i == T2CL;
	assign t2_load_o     = acc_wr && adr_i == T2CH;
	assign ier_wr_o      = acc_wr && adr_i == IER;

	// flag clears, IFR write bits plus access side effects
	always_comb begin
		irq_clr_o = '0;
		if (acc_wr && adr_i == IFR)
			irq_clr_o = dat_i[NUM_IRQ-1:0];
		irq_clr_o[IRQ_CA1] = irq_clr_o[IRQ_CA1] | (cs_i && adr_i == PA);
		irq_clr_o[IRQ_CB1] = irq_clr_o[IRQ_CB1] | (cs_i && adr_i == PB);
		irq_clr_o[IRQ_T1]  = irq_clr_o[IRQ_T1] | (acc_rd && adr_i == T1CL) | t1_load_o;
		irq_clr_o[IRQ_T2]  = irq_clr_o[IRQ_T2] | (acc_rd && adr_i == T2CL) | t2_load_o;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			acr_q <= '0;
			pcr_q <= '0;
			ack_o <= 1'b0;
		end else begin
			if (acc_wr && adr_i == ACR)
				acr_q <= dat_i[7:0];
			if (acc_wr && adr_i == PCR)
				pcr_q <= dat_i[7:0];
			ack_o <= cs_i; // single cycle, no wait states
		end
	end

	assign pa_le_o   = acr_q[ACR_PA_LE];
	assign pb_le_o   = acr_q[ACR_PB_LE];
	assign ca1_pos_o = pcr_q[PCR_CA1_POS];
	assign cb1_pos_o = pcr_q[PCR_CB1_POS];
	assign t1_mode_o = acr_q[ACR_T1_FREE] ? FREERUN : ONESHOT;
	assign t2_mode_o = acr_q[ACR_T2_PULSE] ? PULSE_COUNT : ONESHOT;

	// ==============================
	// read mux
	// ==============================
	always_comb begin
		rdata = '0;
		case (adr_i)
			PA:               rdata = word_t'(pa_rd_i);
			PB:               rdata = word_t'(pb_rd_i);
			T1CL, T1CH:       rdata = word_t'(t1_count_i);
			T1LL, T1LH:       rdata = word_t'(t1_latch_i);
			T2CL, T2CH:       rdata = word_t'(t2_count_i);
			ACR:              rdata = word_t'(acr_q);
			PCR:              rdata = word_t'(pcr_q);
			IFR: begin
				rdata[NUM_IRQ-1:0] = ifr_i;
				rdata[IFR_ANY]     = irq_i; // summary bit
			end
			IER:              rdata = word_t'(ier_i);
			default:          rdata = '0; // ddr is write only, oe pins show it
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (acc_rd)
			dat_o <= rdata; // held until the next read
	end

	a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_o |=> !ack_o);

	// written T2CH value must land in the timer latch
	a_t2_load: assert property (@(posedge clk_i) disable iff (rst_i)
		t2_load_o |=> t2_latch_i == $past(dat_i[TIMER_W-1:0]));

endmodule

// File: design/via_top.sv
`timescale 1ns/10ps

module via_top import via_pkg::*; #(
	parameter int PORT_W  = 32,
	parameter int TIMER_W = 32
) (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              cs_i,
	input  logic              we_i,
	input  reg_addr_e         adr_i,
	input  logic [3:0]        sel_i,
	input  word_t             dat_i,
	input  logic              ca1_i,
	input  logic              cb1_i,
	input  logic [PORT_W-1:0] pa_i,
	input  logic [PORT_W-1:0] pb_i,
	output logic              ack_o,
	output word_t             dat_o,
	output logic              irq_o,
	output logic [PORT_W-1:0] pa_o,
	output logic [PORT_W-1:0] pa_oe_o,
	output logic [PORT_W-1:0] pb_o,
	output logic [PORT_W-1:0] pb_oe_o
);

	// ==============================
	// internal nets
	// ==============================
	logic               pa_out_wr;
	logic               pa_ddr_wr;
	logic               pb_out_wr;
	logic               pb_ddr_wr;
	logic               pa_le;
	logic               pb_le;
	logic               ca1_pos;
	logic               cb1_pos;
	logic [PORT_W-1:0]  pa_rd;
	logic [PORT_W-1:0]  pb_rd;
	logic               ca1_evt;
	logic               cb1_evt;
	logic               t1_latch_wr;
	logic               t1_load;
	timer_mode_e        t1_mode;
	logic               t2_latch_wr;
	logic               t2_load;
	timer_mode_e        t2_mode;
	logic [TIMER_W-1:0] t1_count;
	logic [TIMER_W-1:0] t1_latch;
	logic [TIMER_W-1:0] t2_count;
	logic [TIMER_W-1:0] t2_latch;
	logic               t1_zero;
	logic               t2_zero;
	logic [NUM_IRQ-1:0] irq_evt;
	logic [NUM_IRQ-1:0] irq_clr;
	logic [NUM_IRQ-1:0] ifr;
	logic [NUM_IRQ-1:0] ier;
	logic               ier_wr;

	assign irq_evt[IRQ_CA1] = ca1_evt;
	assign irq_evt[IRQ_CB1] = cb1_evt;
	assign irq_evt[IRQ_T1]  = t1_zero;
	assign irq_evt[IRQ_T2]  = t2_zero;

	via_regctl #(.PORT_W(PORT_W), .TIMER_W(TIMER_W)) u_regctl (
		.clk_i(clk_i), .rst_i(rst_i), .cs_i(cs_i), .we_i(we_i), .adr_i(adr_i),
		.sel_i(sel_i), .dat_i(dat_i),
		.pa_rd_i(pa_rd), .pb_rd_i(pb_rd),
		.t1_count_i(t1_count), .t1_latch_i(t1_latch),
		.t2_count_i(t2_count), .t2_latch_i(t2_latch),
		.ifr_i(ifr), .ier_i(ier), .irq_i(irq_o),
		.ack_o(ack_o), .dat_o(dat_o),
		.pa_out_wr_o(pa_out_wr), .pa_ddr_wr_o(pa_ddr_wr),
		.pb_out_wr_o(pb_out_wr), .pb_ddr_wr_o(pb_ddr_wr),
		.pa_le_o(pa_le), .pb_le_o(pb_le), .ca1_pos_o(ca1_pos), .cb1_pos_o(cb1_pos),
		.t1_latch_wr_o(t1_latch_wr), .t1_load_o(t1_load), .t1_mode_o(t1_mode),
		.t2_latch_wr_o(t2_latch_wr), .t2_load_o(t2_load), .t2_mode_o(t2_mode),
		.irq_clr_o(irq_clr), .ier_wr_o(ier_wr)
	);

	via_port #(.PORT_W(PORT_W)) u_port_a (
		.clk_i(clk_i), .rst_i(rst_i), .out_wr_i(pa_out_wr), .ddr_wr_i(pa_ddr_wr),
		.sel_i(sel_i), .wdata_i(dat_i), .latch_en_i(pa_le), .edge_pos_i(ca1_pos),
		.strobe_pin_i(ca1_i), .pins_i(pa_i),
		.out_o(pa_o), .oe_o(pa_oe_o), .rd_o(pa_rd), .strobe_evt_o(ca1_evt)
	);

	via_port #(.PORT_W(PORT_W)) u_port_b (
		.clk_i(clk_i), .rst_i(rst_i), .out_wr_i(pb_out_wr), .ddr_wr_i(pb_ddr_wr),
		.sel_i(sel_i), .wdata_i(dat_i), .latch_en_i(pb_le), .edge_pos_i(cb1_pos),
		.strobe_pin_i(cb1_i), .pins_i(pb_i),
		.out_o(pb_o), .oe_o(pb_oe_o), .rd_o(pb_rd), .strobe_evt_o(cb1_evt)
	);

	// both timers see pb6, only t2 mode uses it
	via_timer #(.TIMER_W(TIMER_W)) u_t1 (
		.clk_i(clk_i), .rst_i(rst_i), .mode_i(t1_mode), .latch_wr_i(t1_latch_wr),
		.load_i(t1_load), .wdata_i(dat_i), .pulse_pin_i(pb_i[6]),
		.count_o(t1_count), .latch_o(t1_latch), .zero_evt_o(t1_zero)
	);

	via_timer #(.TIMER_W(TIMER_W)) u_t2 (
		.clk_i(clk_i), .rst_i(rst_i), .mode_i(t2_mode), .latch_wr_i(t2_latch_wr),
		.load_i(t2_load), .wdata_i(dat_i), .pulse_pin_i(pb_i[6]),
		.count_o(t2_count), .latch_o(t2_latch), .zero_evt_o(t2_zero)
	);

	via_irq u_irq (
		.clk_i(clk_i), .rst_i(rst_i), .evt_i(irq_evt), .clr_i(irq_clr),
		.ier_wr_i(ier_wr), .wdata_i(dat_i),
		.ifr_o(ifr), .ier_o(ier), .irq_o(irq_o)
	);

endmodule

// File: tb/via_model.svh
`ifndef VIA_MODEL_SVH
`define VIA_MODEL_SVH

int n_checks = 0;
int n_errors = 0;

// ==============================
// reference model
// ==============================
function automatic word_t xorshift(input word_t x);
	word_t y;
	y = x;
	y = y ^ (y << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// byte lanes with sel set take the new data
function automatic word_t lane_merge(input word_t old, input word_t wdata, input logic [3:0] sel);
	word_t res;
	int    b;
	res = old;
	for (b = 0; b < 4; b++) begin
		if (sel[b])
			res[b*8 +: 8] = wdata[b*8 +: 8];
	end
	return res;
endfunction

function automatic word_t port_read(input word_t out, input word_t ddr, input word_t pins);
	word_t res;
	int    i;
	for (i = 0; i < 32; i++)
		res[i] = ddr[i] ? out[i] : pins[i]; // outputs show the latch
	return res;
endfunction

function automatic logic [NUM_IRQ-1:0] ier_update(input logic [NUM_IRQ-1:0] ier,
		input word_t wdata);
	logic [NUM_IRQ-1:0] res;
	int                 i;
	res = ier;
	for (i = 0; i < NUM_IRQ; i++) begin
		if (wdata[i])
			res[i] = wdata[IER_SET]; // selected bits follow the set bit
	end
	return res;
endfunction

function automatic logic [NUM_IRQ-1:0] src_mask(input irq_src_e src);
	logic [NUM_IRQ-1:0] m;
	m      = '0;
	m[src] = 1'b1;
	return m;
endfunction

// ==============================
// compare tasks
// ==============================
task automatic check_word(input string what, input word_t got, input word_t exp);
	n_checks++;
	if (got !== exp) begin
		n_errors++;
		$display("FAIL at %0t: %s got %h expected %h", $time, what, got, exp);
	end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
	n_checks++;
	if (got !== exp) begin
		n_errors++;
		$display("FAIL at %0t: %s got %b expected %b", $time, what, got, exp);
	end
endtask

task automatic check_flags(input string what, input logic [NUM_IRQ-1:0] got,
		input logic [NUM_IRQ-1:0] exp);
	n_checks++;
	if (got !== exp) begin
		n_errors++;
		$display("FAIL at %0t: %s got %b expected %b", $time, what, got, exp);
	end
endtask

`endif

// File: tb/tb_via.sv
`timescale 1ns/10ps

module tb_via import via_pkg::*; ();

	localparam int PORT_W   = 32;
	localparam int TIMER_W  = 32;
	localparam int ACK_TMO  = 8;
	localparam int FLAG_TMO = 200; // polls or cycles

	logic              clk_i;
	logic              rst_i;
	logic              cs_i;
	logic              we_i;
	reg_addr_e         adr_i;
	logic [3:0]        sel_i;
	word_t             dat_i;
	word_t             dat_o;
	logic              ack_o;
	logic              irq_o;
	logic              ca1_i;
	logic              cb1_i;
	logic [PORT_W-1:0] pa_i;
	logic [PORT_W-1:0] pb_i;
	logic [PORT_W-1:0] pa_o;
	logic [PORT_W-1:0] pa_oe_o;
	logic [PORT_W-1:0] pb_o;
	logic [PORT_W-1:0] pb_oe_o;

	// expected register state
	word_t              exp_pa_out = '0;
	word_t              exp_pa_ddr = '0;
	word_t              exp_pb_out = '0;
	word_t              exp_pb_ddr = '0;
	logic [NUM_IRQ-1:0] exp_ier    = '0;
	word_t              rng        = 32'h8828a711;
	logic               mon_en     = 1'b0;

	`include "via_model.svh"

	via_top #(.PORT_W(PORT_W), .TIMER_W(TIMER_W)) i_dut (
		.clk_i(clk_i), .rst_i(rst_i), .cs_i(cs_i), .we_i(we_i), .adr_i(adr_i),
		.sel_i(sel_i), .dat_i(dat_i), .ca1_i(ca1_i), .cb1_i(cb1_i),
		.pa_i(pa_i), .pb_i(pb_i), .ack_o(ack_o), .dat_o(dat_o), .irq_o(irq_o),
		.pa_o(pa_o), .pa_oe_o(pa_oe_o), .pb_o(pb_o), .pb_oe_o(pb_oe_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	// port outputs against the shadow registers, mid cycle
	always @(negedge clk_i) begin
		if (mon_en) begin
			check_word("pa_o", pa_o, exp_pa_out);
			check_word("pa_oe_o", pa_oe_o, exp_pa_ddr);
			check_word("pb_o", pb_o, exp_pb_out);
			check_word("pb_oe_o", pb_oe_o, exp_pb_ddr);
		end
	end

	task automatic stop_on_timeout(input string what);
		$display("timeout while %s", what);
		$display("%0d checks, %0d errors", n_checks, n_errors);
		$display("TESTS FAILED");
		$finish;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk_i);
			#2;
		end
	endtask

	// ==============================
	// bus access
	// ==============================
	task automatic bus_access(input logic wr, input reg_addr_e a, input word_t d,
			input logic [3:0] s, output word_t rdata);
		int n;
		cs_i  = 1'b1;
		we_i  = wr;
		adr_i = a;
		sel_i = s;
		dat_i = d;
		@(posedge clk_i);
		#2;
		cs_i = 1'b0;
		we_i = 1'b0;
		if (wr) begin
			case (a) // register effects of the write
				PA:      exp_pa_out = lane_merge(exp_pa_out, d, s);
				DDRA:    exp_pa_ddr = lane_merge(exp_pa_ddr, d, s);
				PB:      exp_pb_out = lane_merge(exp_pb_out, d, s);
				DDRB:    exp_pb_ddr = lane_merge(exp_pb_ddr, d, s);
				IER:     exp_ier = ier_update(exp_ier, d);
				default: ;
			endcase
		end
		n = 0;
		while (!ack_o && n < ACK_TMO) begin
			@(posedge clk_i);
			#2;
			n++;
		end
		if (!ack_o)
			stop_on_timeout($sformatf("waiting for ack_o on %s", a.name()));
		else begin
			rdata = dat_o;
			@(posedge clk_i);
			#2;
			check_bit("ack_o single cycle", ack_o, 1'b0);
		end
	endtask

	task automatic bus_write(input reg_addr_e a, input word_t d, input logic [3:0] s);
		word_t unused;
		bus_access(1'b1, a, d, s, unused);
	endtask

	task automatic bus_read(input reg_addr_e a, output word_t d);
		bus_access(1'b0, a, '0, 4'hF, d);
	endtask

	task automatic wait_flag(input irq_src_e src, output word_t ifr);
		int n;
		n = 0;
		bus_read(IFR, ifr);
		while (!ifr[src] && n < FLAG_TMO) begin
			bus_read(IFR, ifr);
			n++;
		end
		if (!ifr[src])
			stop_on_timeout($sformatf("waiting for IFR flag %s", src.name()));
	endtask

	task automatic wait_irq(input logic level, input string what);
		int n;
		n = 0;
		while (irq_o !== level && n < FLAG_TMO) begin
			@(posedge clk_i);
			#2;
			n++;
		end
		if (irq_o !== level)
			stop_on_timeout(what);
	endtask

	task automatic pulse_pb6();
		pb_i[6] = 1'b0; // falling edge counts
		idle(3);
		pb_i[6] = 1'b1;
		idle(3);
	endtask

	initial begin
		word_t     rd;
		word_t     ifr;
		word_t     v0;
		word_t     v1;
		word_t     n;
		reg_addr_e a;
		int        i;
		rst_i = 1'b1;
		cs_i  = 1'b0;
		we_i  = 1'b0;
		adr_i = PB;
		sel_i = 4'h0;
		dat_i = '0;
		ca1_i = 1'b0;
		cb1_i = 1'b0;
		pa_i  = '0;
		pb_i  = '0;
		repeat (10) @(posedge clk_i);
		#2;
		rst_i  = 1'b0;
		mon_en = 1'b1;

		// ==============================
		// port writes and direction
		// ==============================
		for (i = 0; i < 32; i++) begin
			rng = xorshift(rng);
			case (rng[1:0])
				2'd0:    a = PA;
				2'd1:    a = DDRA;
				2'd2:    a = PB;
				default: a = DDRB;
			endcase
			v0  = rng;
			rng = xorshift(rng);
			bus_write(a, rng, v0[7:4]);
			rng  = xorshift(rng);
			pa_i = rng;
			rng  = xorshift(rng);
			pb_i = rng;
			idle(1); // read path is registered
			bus_read(PA, rd);
			check_word("PA read", rd, port_read(exp_pa_out, exp_pa_ddr, pa_i));
			bus_read(PB, rd);
			check_word("PB read", rd, port_read(exp_pb_out, exp_pb_ddr, pb_i));
		end

		// input latching on cb1 rising edge
		bus_write(DDRB, '0, 4'hF);
		rng  = xorshift(rng);
		v0   = rng;
		v1   = ~rng;
		pb_i = v0;
		bus_write(PCR, 32'd1 << PCR_CB1_POS, 4'hF);
		bus_write(ACR, 32'd1 << ACR_PB_LE, 4'hF);
		bus_write(IFR, 32'hF, 4'hF);
		pb_i = v1;
		idle(3);
		bus_read(PB, rd);
		check_word("PB held before CB1 edge", rd, port_read(exp_pb_out, exp_pb_ddr, v0));
		cb1_i = 1'b1;
		wait_flag(IRQ_CB1, ifr);
		check_flags("IFR after CB1 edge", ifr[NUM_IRQ-1:0], src_mask(IRQ_CB1));
		bus_read(PB, rd);
		check_word("PB after CB1 edge", rd, port_read(exp_pb_out, exp_pb_ddr, v1));
		bus_read(IFR, ifr);
		check_flags("IFR after PB read", ifr[NUM_IRQ-1:0], '0);
		cb1_i = 1'b0;
		bus_write(ACR, '0, 4'hF);
		bus_write(PCR, '0, 4'hF);

		// ==============================
		// timer 1
		// ==============================
		rng = xorshift(rng);
		n   = 32'd4 + (rng & 32'd7);
		bus_write(IFR, 32'hF, 4'hF);
		bus_write(T1CH, n, 4'hF);
		wait_flag(IRQ_T1, ifr);
		check_flags("IFR after T1 one-shot", ifr[NUM_IRQ-1:0], src_mask(IRQ_T1));
		bus_read(T1CL, rd);
		idle(4 * n + 8); // one-shot wraps, no second zero
		bus_read(IFR, ifr);
		check_bit("T1 one-shot fires once", ifr[IRQ_T1], 1'b0);

		bus_write(ACR, 32'd1 << ACR_T1_FREE, 4'hF);
		bus_write(T1CH, n, 4'hF);
		wait_flag(IRQ_T1, ifr);
		bus_read(T1CL, rd);
		wait_flag(IRQ_T1, ifr);
		check_flags("IFR after T1 free-run reload", ifr[NUM_IRQ-1:0], src_mask(IRQ_T1));
		bus_read(T1LH, rd);
		check_word("T1 latch", rd, n);
		for (i = 0; i < 8; i++) begin
			bus_read(T1CL, rd);
			check_bit("T1 count within latch", rd <= n, 1'b1);
			idle(i);
		end
		bus_write(T1CH, 32'hFFFF_FFFF, 4'hF);
		bus_write(ACR, '0, 4'hF);

		// timer 2 counting pb6 falling edges
		pb_i[6] = 1'b1;
		idle(3);
		rng = xorshift(rng);
		n   = 32'd2 + (rng & 32'd3);
		bus_write(ACR, 32'd1 << ACR_T2_PULSE, 4'hF);
		bus_write(T2CH, n, 4'hF);
		bus_write(IFR, 32'hF, 4'hF);
		for (i = 0; i < int'(n); i++)
			pulse_pb6();
		bus_read(IFR, ifr);
		check_bit("T2 flag after N pulses", ifr[IRQ_T2], 1'b0);
		pulse_pb6();
		wait_flag(IRQ_T2, ifr);
		bus_write(ACR, '0, 4'hF);

		// ==============================
		// interrupts
		// ==============================
		bus_write(PCR, 32'd1 << PCR_CA1_POS, 4'hF);
		bus_write(IFR, 32'hF, 4'hF);
		bus_write(IER, (32'd1 << IER_SET) | 32'(src_mask(IRQ_T1)), 4'hF);
		bus_read(IER, rd);
		check_flags("IER after T1 enable", rd[NUM_IRQ-1:0], exp_ier);
		check_bit("irq_o before T1 zero", irq_o, 1'b0);
		rng = xorshift(rng);
		bus_write(T1CH, 32'd3 + (rng & 32'd7), 4'hF);
		wait_irq(1'b1, "irq_o rising on T1");
		bus_read(IFR, ifr);
		check_bit("IFR summary bit with T1", ifr[IFR_ANY], 1'b1);
		check_bit("IFR T1 flag", ifr[IRQ_T1], 1'b1);
		bus_write(IFR, 32'(src_mask(IRQ_T1)), 4'hF);
		wait_irq(1'b0, "irq_o falling after IFR write");

		ca1_i = 1'b1; // masked source
		wait_flag(IRQ_CA1, ifr);
		idle(2);
		check_bit("irq_o with CA1 masked", irq_o, 1'b0);
		check_bit("IFR summary with CA1 masked", ifr[IFR_ANY], 1'b0);
		for (i = 0; i < 8; i++) begin
			rng = xorshift(rng);
			bus_write(IER, rng, 4'hF);
			bus_read(IER, rd);
			check_flags("IER read back", rd[NUM_IRQ-1:0], exp_ier);
		end

		mon_en = 1'b0;
		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: build.f
design/via_pkg.sv
design/via_port.sv
design/via_timer.sv
design/via_irq.sv
design/via_regctl.sv
design/via_top.sv
+incdir+tb
tb/tb_via.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_via
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TESTS FAILED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
